// File: verilog/rpi_bus_pkg.sv
/* shared widths, typedefs and the status bank map for the parallel host bus
   a data word is two bus halves, most significant half first
   address bit 15 picks the bank, the bits below it are the word offset */
package rpi_bus_pkg;

	localparam int BUS_WIDTH = 16;
	localparam int NUMBER_OF_BANKS = 2;
	localparam int OFFSET_WIDTH = 15; // address bits below the bank bit

	typedef logic [BUS_WIDTH-1:0] halfword_t; // one bus transaction
	typedef logic [OFFSET_WIDTH:0] address_t; // msb is the bank
	typedef logic [2*BUS_WIDTH-1:0] data_word_t; // two transactions
	typedef logic [31:0] count_t;
	typedef logic [NUMBER_OF_BANKS-1:0] bank_strobe_t; // one strobe per bank
	typedef logic [OFFSET_WIDTH-1:0] offset_t;

	// word offsets inside bank 1
	localparam offset_t STATUS_ID = 15'd0;
	localparam offset_t STATUS_WRITES = 15'd1;
	localparam offset_t STATUS_READS = 15'd2;
	localparam offset_t STATUS_READ_ERRORS = 15'd3;
	localparam offset_t STATUS_WRITE_ERRORS = 15'd4;
	localparam offset_t STATUS_ADDRESS_ERRORS = 15'd5;

	localparam data_word_t STATUS_ID_VALUE = 32'h5242_0001; // "RB" rev 1

endpackage

// File: verilog/scratch_memory_bank.sv
/* bank 0 scratch memory of 2**MEM_ADDRESS_WIDTH data words
   offset bits above MEM_ADDRESS_WIDTH alias; read data lags the address by one cycle
   contents are not cleared by reset */
module scratch_memory_bank
	import rpi_bus_pkg::*;
#(
	parameter int MEM_ADDRESS_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input address_t address_word,
	input data_word_t write_data_word,
	input logic write_strobe,
	output data_word_t read_word
);

	localparam int DEPTH = 2 ** MEM_ADDRESS_WIDTH;

	data_word_t memory [DEPTH];
	logic [MEM_ADDRESS_WIDTH-1:0] index;

	if (MEM_ADDRESS_WIDTH > OFFSET_WIDTH) begin : g_depth_check
		$error("MEM_ADDRESS_WIDTH exceeds the address offset width");
	end

	assign index = address_word[MEM_ADDRESS_WIDTH-1:0]; // bank bit is ignored here

	always_ff @(posedge clock) begin
		if (write_strobe) begin
			memory[index] <= write_data_word;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			read_word <= '0;
		end else begin
			read_word <= memory[index]; // one cycle latency
		end
	end

endmodule

// File: verilog/status_register_bank.sv
/* bank 1 status words polled by the host, read combinationally by offset
   any completed write to this bank clears all five counters; counters wrap */
module status_register_bank
	import rpi_bus_pkg::*;
(
	input logic clock,
	input logic reset,
	input address_t address_word,
	input logic scratch_write,
	input logic write_strobe,
	input logic read_done,
	input logic read_error,
	input logic write_error,
	input logic address_error,
	output data_word_t read_word
);

	count_t write_count;
	count_t read_count;
	count_t read_error_count;
	count_t write_error_count;
	count_t address_error_count;
	offset_t offset;

	assign offset = address_word[OFFSET_WIDTH-1:0];

	always_ff @(posedge clock) begin
		if (reset || write_strobe) begin
			write_count <= '0;
			read_count <= '0;
			read_error_count <= '0;
			write_error_count <= '0;
			address_error_count <= '0;
		end else begin
			if (scratch_write) begin
				write_count <= write_count + 1'b1; // completed bank 0 words
			end
			if (read_done) begin
				read_count <= read_count + 1'b1; // either bank
			end
			if (read_error) begin
				read_error_count <= read_error_count + 1'b1;
			end
			if (write_error) begin
				write_error_count <= write_error_count + 1'b1;
			end
			if (address_error) begin
				address_error_count <= address_error_count + 1'b1;
			end
		end
	end

	always_comb begin
		case (offset)
			STATUS_ID: read_word = STATUS_ID_VALUE;
			STATUS_WRITES: read_word = write_count;
			STATUS_READS: read_word = read_count;
			STATUS_READ_ERRORS: read_word = read_error_count;
			STATUS_WRITE_ERRORS: read_word = write_error_count;
			STATUS_ADDRESS_ERRORS: read_word = address_error_count;
			default: read_word = '0; // unmapped offsets
		endcase
	end

	// the front end strobes one bank per completed word
	a_one_bank_per_write: assert property (@(posedge clock) disable iff (reset)
		!(write_strobe && scratch_write))
		else $error("status and scratch write strobes high together");

endmodule

// File: verilog/half_duplex_rpi_bus.sv
/* host levels are asynchronous and pass through SYNC_STAGES flops (3 or more)
   ack_valid follows enable by SYNC_STAGES+1 cycles both ways; no other handshake
   the bus is split into bus_in, bus_out and bus_drive, the tri-state pad is external */
module half_duplex_rpi_bus
	import rpi_bus_pkg::*;
#(
	parameter int SYNC_STAGES = 3,
	parameter bit AUTOINCREMENT = 1
) (
	input logic clock,
	input logic reset,
	input halfword_t bus_in,
	input logic read, // 1 = read, 0 = write
	input logic register_select, // 0 = address, 1 = data
	input logic enable,
	input data_word_t scratch_read_word,
	input data_word_t status_read_word,
	output halfword_t bus_out,
	output logic bus_drive,
	output logic ack_valid,
	output address_t address_word,
	output data_word_t write_data_word,
	output bank_strobe_t write_strobe,
	output logic read_done,
	output logic read_error,
	output logic write_error,
	output logic address_error
);

	typedef enum logic {
		ADDRESS_IDLE,
		ADDRESS_ACTIVE // half taken, commit when enable drops
	} address_state_t;

	typedef enum logic [1:0] {
		WRITE_IDLE,
		WRITE_HIGH_ACTIVE,
		WRITE_WAIT_LOW,
		WRITE_LOW_ACTIVE
	} write_state_t;

	typedef enum logic [1:0] {
		READ_IDLE,
		READ_HIGH_ACTIVE,
		READ_WAIT_LOW,
		READ_LOW_ACTIVE
	} read_state_t;

	logic [SYNC_STAGES-1:0] enable_sync;
	logic [SYNC_STAGES-1:0] read_sync;
	logic [SYNC_STAGES-1:0] register_select_sync;
	halfword_t bus_sync [SYNC_STAGES];

	logic enable_high;
	logic enable_low;
	logic read_level;
	logic select_level;
	halfword_t bus_level;
	logic start;
	logic finish;
	logic address_start;
	logic read_start;
	logic write_start;
	logic abort_write;
	logic abort_read;

	address_state_t address_state;
	write_state_t write_state;
	read_state_t read_state;
	halfword_t address_half;
	data_word_t selected_read_word;
	data_word_t read_word_latched;
	address_t next_address;

	if (SYNC_STAGES < 3) begin : g_sync_check
		$error("SYNC_STAGES must be at least 3");
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_sync <= '0;
			read_sync <= '0;
			register_select_sync <= '0;
		end else begin
			enable_sync <= {enable_sync[SYNC_STAGES-2:0], enable};
			read_sync <= {read_sync[SYNC_STAGES-2:0], read};
			register_select_sync <= {register_select_sync[SYNC_STAGES-2:0], register_select};
		end
	end

	always_ff @(posedge clock) begin
		bus_sync[0] <= bus_in;
		for (int i = 1; i < SYNC_STAGES; i++) begin
			bus_sync[i] <= bus_sync[i-1];
		end
	end

	assign enable_high = enable_sync[SYNC_STAGES-1 -: 2] == 2'b11;
	assign enable_low = enable_sync[SYNC_STAGES-1 -: 2] == 2'b00;
	assign read_level = read_sync[SYNC_STAGES-1];
	assign select_level = register_select_sync[SYNC_STAGES-1];
	assign bus_level = bus_sync[SYNC_STAGES-1];

	assign start = enable_high && !ack_valid; // cycle that ack_valid rises
	assign finish = enable_low && ack_valid; // first idle cycle after enable falls
	assign address_start = start && !select_level;
	assign read_start = start && select_level && read_level;
	assign write_start = start && select_level && !read_level;

	// another kind arriving part-way through a word
	assign abort_write = (address_start || read_start) && write_state != WRITE_IDLE;
	assign abort_read = (address_start || write_start) && read_state != READ_IDLE;

	assign bus_drive = read;
	assign selected_read_word = address_word[OFFSET_WIDTH] ? status_read_word : scratch_read_word;
	assign next_address = {address_word[OFFSET_WIDTH], address_word[OFFSET_WIDTH-1:0] + 1'b1};

	// strobed while address_word still holds this word's offset
	always_comb begin
		write_strobe = '0;
		if (!reset && finish && write_state == WRITE_LOW_ACTIVE) begin
			write_strobe[address_word[OFFSET_WIDTH]] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_valid <= 1'b0;
		end else if (start) begin
			ack_valid <= 1'b1;
		end else if (finish) begin
			ack_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		read_done <= 1'b0; // all pulses last one cycle
		read_error <= 1'b0;
		write_error <= 1'b0;
		address_error <= 1'b0;
		if (reset) begin
			address_state <= ADDRESS_IDLE;
			write_state <= WRITE_IDLE;
			read_state <= READ_IDLE;
			address_word <= '0;
			bus_out <= '0;
		end else if (start) begin
			if (abort_write) begin
				write_error <= 1'b1;
				write_state <= WRITE_IDLE;
			end
			if (abort_read) begin
				read_error <= 1'b1;
				read_state <= READ_IDLE;
			end
			if (address_start) begin
				if (read_level) begin
					address_error <= 1'b1; // address register is write only
				end else begin
					address_state <= ADDRESS_ACTIVE;
				end
			end else if (read_start) begin
				if (read_state == READ_WAIT_LOW) begin
					bus_out <= read_word_latched[BUS_WIDTH-1:0];
					read_state <= READ_LOW_ACTIVE;
				end else begin
					bus_out <= read_word_latched[2*BUS_WIDTH-1:BUS_WIDTH];
					read_state <= READ_HIGH_ACTIVE;
				end
			end else begin
				if (write_state == WRITE_WAIT_LOW) begin
					write_state <= WRITE_LOW_ACTIVE;
				end else begin
					write_state <= WRITE_HIGH_ACTIVE;
				end
			end
		end else if (finish) begin
			if (address_state == ADDRESS_ACTIVE) begin
				address_word <= address_half;
				address_state <= ADDRESS_IDLE;
			end
			case (write_state)
				WRITE_HIGH_ACTIVE: write_state <= WRITE_WAIT_LOW;
				WRITE_LOW_ACTIVE: begin
					write_state <= WRITE_IDLE;
					if (AUTOINCREMENT) begin
						address_word <= next_address; // stays inside the bank
					end
				end
				default: ;
			endcase
			case (read_state)
				READ_HIGH_ACTIVE: read_state <= READ_WAIT_LOW;
				READ_LOW_ACTIVE: begin
					read_state <= READ_IDLE;
					read_done <= 1'b1;
					if (AUTOINCREMENT) begin
						address_word <= next_address;
					end
				end
				default: ;
			endcase
		end
	end

	// halves are stored on the start cycle
	always_ff @(posedge clock) begin
		if (write_start) begin
			if (write_state == WRITE_WAIT_LOW) begin
				write_data_word[BUS_WIDTH-1:0] <= bus_level;
			end else begin
				write_data_word[2*BUS_WIDTH-1:BUS_WIDTH] <= bus_level;
			end
		end
		if (address_start && !read_level) begin
			address_half <= bus_level;
		end
	end

	// follows the selected bank while idle; the scratch read latency and
	// this register settle well before the synchronized enable can rise
	always_ff @(posedge clock) begin
		if (enable_low && read_state == READ_IDLE) begin
			read_word_latched <= selected_read_word;
		end
	end

	a_single_bank_strobe: assert property (@(posedge clock) disable iff (reset)
		write_strobe != '0 |=> write_strobe == '0)
		else $error("write_strobe = %b held for more than one cycle", write_strobe);

	a_ack_needs_enable: assert property (@(posedge clock) disable iff (reset)
		$rose(ack_valid) |-> $past(enable, SYNC_STAGES + 1))
		else $error("ack_valid rose without enable high SYNC_STAGES+1 cycles before");

endmodule

// File: verilog/rpi_bus_subsystem_top.sv
/* parallel host bus peripheral: front end, bank 0 scratch and bank 1 status
   bus_in, bus_out and bus_drive are joined into one tri-state bus by an external pad */
module rpi_bus_subsystem_top
	import rpi_bus_pkg::*;
#(
	parameter int SYNC_STAGES = 3,
	parameter int MEM_ADDRESS_WIDTH = 8,
	parameter bit AUTOINCREMENT = 1
) (
	input logic clock,
	input logic reset,
	input halfword_t bus_in,
	input logic read,
	input logic register_select,
	input logic enable,
	output halfword_t bus_out,
	output logic bus_drive, // high while the peripheral owns the bus
	output logic ack_valid
);

	address_t address_word;
	data_word_t write_data_word;
	bank_strobe_t write_strobe;
	logic read_done;
	logic read_error;
	logic write_error;
	logic address_error;
	data_word_t scratch_read_word;
	data_word_t status_read_word;

	half_duplex_rpi_bus #(
		.SYNC_STAGES(SYNC_STAGES),
		.AUTOINCREMENT(AUTOINCREMENT)
	) bus_front_end (
		.clock(clock),
		.reset(reset),
		.bus_in(bus_in),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.scratch_read_word(scratch_read_word),
		.status_read_word(status_read_word),
		.bus_out(bus_out),
		.bus_drive(bus_drive),
		.ack_valid(ack_valid),
		.address_word(address_word),
		.write_data_word(write_data_word),
		.write_strobe(write_strobe),
		.read_done(read_done),
		.read_error(read_error),
		.write_error(write_error),
		.address_error(address_error)
	);

	scratch_memory_bank #(
		.MEM_ADDRESS_WIDTH(MEM_ADDRESS_WIDTH)
	) scratch_bank (
		.clock(clock),
		.reset(reset),
		.address_word(address_word),
		.write_data_word(write_data_word),
		.write_strobe(write_strobe[0]), // bank 0
		.read_word(scratch_read_word)
	);

	status_register_bank status_bank (
		.clock(clock),
		.reset(reset),
		.address_word(address_word),
		.scratch_write(write_strobe[0]),
		.write_strobe(write_strobe[1]), // bank 1 write clears the counters
		.read_done(read_done),
		.read_error(read_error),
		.write_error(write_error),
		.address_error(address_error),
		.read_word(status_read_word)
	);

endmodule

// File: verif/rpi_bus_tb.sv
/* host model for the parallel bus peripheral, paced only by ack_valid
   every read word is checked against a model of scratch memory and status counters
   addresses used stay below 2**MEM_ADDRESS_WIDTH so no scratch aliasing occurs */
module rpi_bus_tb
	import rpi_bus_pkg::*;
();

	localparam int SYNC_STAGES = 3;
	localparam int MEM_ADDRESS_WIDTH = 8;
	localparam int TRANSACTION_COUNT = 73; // host transactions in the sequence below
	localparam int CYCLE_LIMIT = 40 * TRANSACTION_COUNT;

	logic clock = 1'b0;
	logic reset;
	halfword_t bus_in;
	logic read;
	logic register_select;
	logic enable;
	halfword_t bus_out;
	logic bus_drive;
	logic ack_valid;

	data_word_t scratch_model [2**MEM_ADDRESS_WIDTH];
	address_t model_address;
	count_t model_writes;
	count_t model_reads;
	count_t model_read_errors;
	count_t model_write_errors;
	count_t model_address_errors;

	data_word_t actual_words [$]; // filled by the host, drained by the compare process
	data_word_t expected_words [$];
	address_t checked_addresses [$];

	integer seed = 32'h392b_9348;
	int cycle_count = 0;
	int check_count = 0;
	int word_error_count = 0;
	int drive_error_count = 0;
	int words_read = 0;
	int transactions = 0;

	rpi_bus_subsystem_top #(
		.SYNC_STAGES(SYNC_STAGES),
		.MEM_ADDRESS_WIDTH(MEM_ADDRESS_WIDTH),
		.AUTOINCREMENT(1'b1)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.bus_in(bus_in),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.bus_out(bus_out),
		.bus_drive(bus_drive),
		.ack_valid(ack_valid)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the host sequence did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	// expected word for a read at this address, from the model state
	function automatic data_word_t expected_word(input address_t address);
		offset_t offset;
		offset = address[OFFSET_WIDTH-1:0];
		if (!address[OFFSET_WIDTH]) begin
			return scratch_model[address[MEM_ADDRESS_WIDTH-1:0]];
		end
		case (offset)
			STATUS_ID: return STATUS_ID_VALUE;
			STATUS_WRITES: return model_writes;
			STATUS_READS: return model_reads;
			STATUS_READ_ERRORS: return model_read_errors;
			STATUS_WRITE_ERRORS: return model_write_errors;
			STATUS_ADDRESS_ERRORS: return model_address_errors;
			default: return '0;
		endcase
	endfunction

	task automatic advance_model_address();
		model_address = model_address + 16'd1; // next word after each completed word
	endtask

	task automatic clear_model_counters();
		model_writes = '0;
		model_reads = '0;
		model_read_errors = '0;
		model_write_errors = '0;
		model_address_errors = '0;
	endtask

	task automatic wait_for_ack(input logic level);
		@(posedge clock);
		while (ack_valid !== level) begin
			@(posedge clock);
		end
	endtask

	task automatic bus_transaction(input logic is_read, input logic is_data,
			input halfword_t value, output halfword_t sampled);
		@(posedge clock);
		read <= is_read;
		register_select <= is_data;
		bus_in <= value;
		@(posedge clock); // levels settle a cycle before enable
		enable <= 1'b1;
		wait_for_ack(1'b1);
		sampled = bus_out;
		assert (bus_drive === is_read) else begin
			drive_error_count++;
			$display("ERROR: bus_drive = %h, expected %h", bus_drive, is_read);
		end
		enable <= 1'b0;
		wait_for_ack(1'b0);
		transactions++;
	endtask

	task automatic set_address(input address_t address);
		halfword_t ignored;
		bus_transaction(1'b0, 1'b0, address, ignored);
		model_address = address;
	endtask

	task automatic write_half(input halfword_t half);
		halfword_t ignored;
		bus_transaction(1'b0, 1'b1, half, ignored);
	endtask

	task automatic write_word(input data_word_t word);
		write_half(word[31:16]); // most significant half first
		write_half(word[15:0]);
		if (model_address[OFFSET_WIDTH]) begin
			clear_model_counters(); // any bank 1 write
		end else begin
			scratch_model[model_address[MEM_ADDRESS_WIDTH-1:0]] = word;
			model_writes = model_writes + 32'd1;
		end
		advance_model_address();
	endtask

	task automatic read_and_check();
		data_word_t expected;
		halfword_t high_half;
		halfword_t low_half;
		expected = expected_word(model_address); // counts before this read
		bus_transaction(1'b1, 1'b1, 16'h0000, high_half);
		bus_transaction(1'b1, 1'b1, 16'h0000, low_half);
		actual_words.push_back({high_half, low_half});
		expected_words.push_back(expected);
		checked_addresses.push_back(model_address);
		model_reads = model_reads + 32'd1;
		words_read++;
		advance_model_address();
	endtask

	always @(posedge clock) begin
		data_word_t actual;
		data_word_t expected;
		address_t address;
		while (actual_words.size() != 0) begin
			actual = actual_words.pop_front();
			expected = expected_words.pop_front();
			address = checked_addresses.pop_front();
			check_count++;
			assert (actual === expected) else begin
				word_error_count++;
				$display("ERROR: bus_out word at address %h = %h, expected %h",
					address, actual, expected);
			end
		end
	end

	initial begin
		data_word_t word;
		reset <= 1'b1;
		bus_in <= '0;
		read <= 1'b0;
		register_select <= 1'b0;
		enable <= 1'b0;
		model_address = '0;
		clear_model_counters();
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (ack_valid === 1'b0 && bus_out === '0) else begin
			drive_error_count++;
			$display("ERROR: after reset ack_valid = %h, bus_out = %h, expected 0 and 0000",
				ack_valid, bus_out);
		end

		set_address({1'b1, STATUS_ID}); // identifier right after reset
		read_and_check();

		set_address(16'h0010);
		for (int i = 0; i < 8; i++) begin
			word = $random(seed);
			write_word(word);
		end
		set_address(16'h0010);
		for (int i = 0; i < 8; i++) begin
			read_and_check();
		end

		set_address(16'h0040);
		write_word(32'ha5c3_3c5a); // a5c3 goes out first, lands in bits 31:16
		set_address(16'h0040);
		read_and_check();

		set_address({1'b1, STATUS_WRITES});
		read_and_check();
		read_and_check();
		set_address({1'b1, STATUS_ID});
		write_word(32'h0000_0000); // clears the counters
		set_address({1'b1, STATUS_WRITES});
		read_and_check();
		read_and_check();

		set_address(16'h0020);
		word = $random(seed);
		write_word(word);
		set_address(16'h0020);
		write_half(16'hdead); // half a word, then cut off
		set_address({1'b1, STATUS_WRITE_ERRORS});
		model_write_errors = model_write_errors + 32'd1;
		read_and_check();
		set_address(16'h0020);
		read_and_check(); // memory untouched
		set_address(16'h0020);
		write_word(32'h1234_5678);
		set_address(16'h0020);
		read_and_check();

		repeat (2) @(posedge clock);
		$display("transactions %0d, word checks %0d, word errors %0d, drive errors %0d",
			transactions, check_count, word_error_count, drive_error_count);
		if (word_error_count == 0 && drive_error_count == 0 && check_count == words_read) begin
			$display("All tests passed");
		end else begin
			if (check_count != words_read) begin
				$display("only %0d of %0d read words were compared", check_count, words_read);
			end
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: files.f
verilog/rpi_bus_pkg.sv
verilog/scratch_memory_bank.sv
verilog/status_register_bank.sv
verilog/half_duplex_rpi_bus.sv
verilog/rpi_bus_subsystem_top.sv
verif/rpi_bus_tb.sv

// File: Makefile
VERILATOR = verilator
VERILATOR_FLAGS = --binary --timing --assert -Wno-fatal
TOP = rpi_bus_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir
PASS_MESSAGE = All tests passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)
